/* source/cpu_settings.svh */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// datapath width
`define DATA_W 32

// register file geometry
`define REG_AW 5
`define NUM_REGS 32

`endif

/* source/isa_pkg.sv */
package isa_pkg;

    // major opcode in instr[31:26]
    typedef enum logic [5:0] {
        op_rtype = 6'h00,
        op_beq   = 6'h04,
        op_addi  = 6'h08,
        op_addiu = 6'h09,
        op_andi  = 6'h0c,
        op_lui   = 6'h0f
    } opcode_e;

    // r-type function in instr[5:0]
    typedef enum logic [5:0] {
        fn_sll = 6'h00,
        fn_add = 6'h20,
        fn_sub = 6'h22,
        fn_and = 6'h24,
        fn_or  = 6'h25,
        fn_slt = 6'h2a
    } funct_e;

    localparam int opcode_hi = 31;
    localparam int opcode_lo = 26;
    localparam int rs_hi     = 25;
    localparam int rs_lo     = 21;
    localparam int rt_hi     = 20;
    localparam int rt_lo     = 16;
    localparam int rd_hi     = 15;
    localparam int rd_lo     = 11;
    localparam int shamt_hi  = 10;
    localparam int shamt_lo  = 6;
    localparam int funct_hi  = 5;
    localparam int funct_lo  = 0;
    localparam int imm_hi    = 15; // 16-bit immediate
    localparam int imm_lo    = 0;

endpackage

/* source/pipe_pkg.sv */
`include "cpu_settings.svh"

package pipe_pkg;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt,
        alu_sll,
        alu_lui // passes operand b through
    } alu_op_e;

    typedef struct packed {
        logic    reg_write;
        logic    alu_src_imm;   // imm as operand b
        logic    alu_src_shamt; // shamt as operand a
        logic    branch;
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        ctrl_t              ctrl;
        logic [`DATA_W-1:0] pc;
        logic [`DATA_W-1:0] rs_data;
        logic [`DATA_W-1:0] rt_data;
        logic [`DATA_W-1:0] imm;
        logic [`REG_AW-1:0] rs;
        logic [`REG_AW-1:0] rt;
        logic [`REG_AW-1:0] rd;    // final destination or 0 without write
        logic [4:0]         shamt;
    } id_ex_t;

    typedef struct packed {
        logic               valid;
        logic [`REG_AW-1:0] rd;
        logic [`DATA_W-1:0] data;
    } wb_t;

endpackage

/* source/decoder.sv */
`timescale 1ns/10ps
`include "cpu_settings.svh"

module decoder (
    input  logic [31:0]        instr,
    input  logic               valid,
    output pipe_pkg::id_ex_t   dec,
    output logic [`REG_AW-1:0] rs,
    output logic [`REG_AW-1:0] rt
);
    logic [5:0]         opcode;
    logic [5:0]         funct;
    logic [`REG_AW-1:0] rd_field;
    logic [4:0]         shamt;
    logic [15:0]        imm16;
    logic [`DATA_W-1:0] imm_ext;
    pipe_pkg::ctrl_t    ctrl;
    logic               known;
    logic               dest_rt;

    assign opcode   = instr[isa_pkg::opcode_hi:isa_pkg::opcode_lo];
    assign rs       = instr[isa_pkg::rs_hi:isa_pkg::rs_lo];
    assign rt       = instr[isa_pkg::rt_hi:isa_pkg::rt_lo];
    assign rd_field = instr[isa_pkg::rd_hi:isa_pkg::rd_lo];
    assign shamt    = instr[isa_pkg::shamt_hi:isa_pkg::shamt_lo];
    assign funct    = instr[isa_pkg::funct_hi:isa_pkg::funct_lo];
    assign imm16    = instr[isa_pkg::imm_hi:isa_pkg::imm_lo];

    always_comb begin
        ctrl    = '0;
        known   = 1'b1;
        dest_rt = 1'b1;
        imm_ext = {{(`DATA_W-16){imm16[15]}}, imm16}; // sign extended by default
        case (isa_pkg::opcode_e'(opcode))
            isa_pkg::op_rtype: begin
                dest_rt        = 1'b0;
                ctrl.reg_write = 1'b1;
                case (isa_pkg::funct_e'(funct))
                    isa_pkg::fn_sll: begin
                        ctrl.alu_op        = pipe_pkg::alu_sll;
                        ctrl.alu_src_shamt = 1'b1;
                    end
                    isa_pkg::fn_add: ctrl.alu_op = pipe_pkg::alu_add;
                    isa_pkg::fn_sub: ctrl.alu_op = pipe_pkg::alu_sub;
                    isa_pkg::fn_and: ctrl.alu_op = pipe_pkg::alu_and;
                    isa_pkg::fn_or:  ctrl.alu_op = pipe_pkg::alu_or;
                    isa_pkg::fn_slt: ctrl.alu_op = pipe_pkg::alu_slt;
                    default:         known = 1'b0;
                endcase
            end
            isa_pkg::op_beq: begin
                ctrl.branch = 1'b1;
                ctrl.alu_op = pipe_pkg::alu_sub;
            end
            isa_pkg::op_addi, isa_pkg::op_addiu: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = pipe_pkg::alu_add;
            end
            isa_pkg::op_andi: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = pipe_pkg::alu_and;
                imm_ext          = {{(`DATA_W-16){1'b0}}, imm16};
            end
            isa_pkg::op_lui: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = pipe_pkg::alu_lui;
                imm_ext          = {imm16, {(`DATA_W-16){1'b0}}};
            end
            default: known = 1'b0;
        endcase
    end

    always_comb begin
        dec       = '0; // data fields filled in by the top
        dec.imm   = imm_ext;
        dec.rs    = rs;
        dec.rt    = rt;
        dec.shamt = shamt;
        if (valid && known) begin
            dec.ctrl = ctrl;
            if (ctrl.reg_write)
                dec.rd = dest_rt ? rt : rd_field;
        end
    end

endmodule

/* source/reg_file.sv */
`timescale 1ns/10ps
`include "cpu_settings.svh"

module reg_file (
    input  logic               clk,
    input  logic               rst,
    input  logic [`REG_AW-1:0] ra,
    input  logic [`REG_AW-1:0] rb,
    output logic [`DATA_W-1:0] rdata_a,
    output logic [`DATA_W-1:0] rdata_b,
    input  pipe_pkg::wb_t      wb
);
    logic [`DATA_W-1:0] regs [`NUM_REGS];
    logic               wr_en;

    assign wr_en = wb.valid && (wb.rd != '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `NUM_REGS; i++)
                regs[i] <= '0;
        end else if (wr_en) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // r0 reads zero and a same-cycle write passes through
    function automatic logic [`DATA_W-1:0] read_port(input logic [`REG_AW-1:0] addr);
        if (addr == '0)
            return '0;
        if (wr_en && (wb.rd == addr))
            return wb.data;
        return regs[addr];
    endfunction

    assign rdata_a = read_port(ra);
    assign rdata_b = read_port(rb);

endmodule

/* source/id_ex_reg.sv */
`timescale 1ns/10ps
`include "cpu_settings.svh"

module id_ex_reg (
    input  logic             clk,
    input  logic             rst,
    input  logic             flush,
    input  pipe_pkg::id_ex_t d,
    output pipe_pkg::id_ex_t q
);
    pipe_pkg::id_ex_t cleared;

    // bubble that keeps the supervisor bit of the pc
    always_comb begin
        cleared                = '0;
        cleared.pc[`DATA_W-1]  = q.pc[`DATA_W-1];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            q <= '0;
        end else if (flush) begin
            q <= cleared; // squash the wrong-path instruction
        end else begin
            q <= d;
        end
    end

endmodule

/* source/ex_stage.sv */
`timescale 1ns/10ps
`include "cpu_settings.svh"

module ex_stage (
    input  logic               clk,
    input  logic               rst,
    input  pipe_pkg::id_ex_t   ex,
    output pipe_pkg::wb_t      wb,
    output logic               redirect,
    output logic [`DATA_W-1:0] redirect_pc
);
    logic               fwd_ok;
    logic [`DATA_W-1:0] op_rs;
    logic [`DATA_W-1:0] op_rt;
    logic [`DATA_W-1:0] a;
    logic [`DATA_W-1:0] b;
    logic [`DATA_W-1:0] result;

    assign fwd_ok = wb.valid && (wb.rd != '0);

    // producer one ahead sits in the result register
    assign op_rs = (fwd_ok && (wb.rd == ex.rs)) ? wb.data : ex.rs_data;
    assign op_rt = (fwd_ok && (wb.rd == ex.rt)) ? wb.data : ex.rt_data;

    assign a = ex.ctrl.alu_src_shamt ? {{(`DATA_W-5){1'b0}}, ex.shamt} : op_rs;
    assign b = ex.ctrl.alu_src_imm ? ex.imm : op_rt;

    always_comb begin
        result = '0;
        case (ex.ctrl.alu_op)
            pipe_pkg::alu_add: result = a + b; // no overflow trap
            pipe_pkg::alu_sub: result = a - b;
            pipe_pkg::alu_and: result = a & b;
            pipe_pkg::alu_or:  result = a | b;
            pipe_pkg::alu_slt: result[0] = $signed(a) < $signed(b);
            pipe_pkg::alu_sll: result = b << a[4:0];
            pipe_pkg::alu_lui: result = b; // imm already shifted up
            default:           result = '0;
        endcase
    end

    assign redirect    = ex.ctrl.branch && (op_rs == op_rt);
    assign redirect_pc = ex.pc + `DATA_W'd4 + {ex.imm[`DATA_W-3:0], 2'b00};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb <= '0;
        end else begin
            wb.valid <= ex.ctrl.reg_write && (ex.rd != '0); // r0 writes dropped
            wb.rd    <= ex.rd;
            wb.data  <= result;
        end
    end

endmodule

/* source/core_slice.sv */
`timescale 1ns/10ps
`include "cpu_settings.svh"

module core_slice (
    input  logic               clk,
    input  logic               rst,
    input  logic               instr_valid,
    input  logic [31:0]        instr,
    input  logic [`DATA_W-1:0] pc,
    output pipe_pkg::wb_t      wb,
    output logic               redirect,
    output logic [`DATA_W-1:0] redirect_pc
);
    pipe_pkg::id_ex_t   dec;
    pipe_pkg::id_ex_t   id_ex_d;
    pipe_pkg::id_ex_t   id_ex_q;
    logic [`REG_AW-1:0] rs;
    logic [`REG_AW-1:0] rt;
    logic [`DATA_W-1:0] rs_data;
    logic [`DATA_W-1:0] rt_data;

    decoder u_dec (.instr(instr), .valid(instr_valid), .dec(dec), .rs(rs), .rt(rt));

    reg_file u_rf (
        .clk(clk), .rst(rst), .ra(rs), .rb(rt),
        .rdata_a(rs_data), .rdata_b(rt_data), .wb(wb)
    );

    // decoded fields plus pc and operands
    assign id_ex_d = '{ctrl: dec.ctrl, pc: pc, rs_data: rs_data, rt_data: rt_data,
                       imm: dec.imm, rs: dec.rs, rt: dec.rt, rd: dec.rd,
                       shamt: dec.shamt};

    id_ex_reg u_id_ex (
        .clk(clk), .rst(rst), .flush(redirect), .d(id_ex_d), .q(id_ex_q)
    );

    ex_stage u_ex (
        .clk(clk), .rst(rst), .ex(id_ex_q), .wb(wb),
        .redirect(redirect), .redirect_pc(redirect_pc)
    );

endmodule

/* test/core_slice_props.sv */
`timescale 1ns/10ps
`include "cpu_settings.svh"

module core_slice_props (
    input logic               clk,
    input logic               rst,
    input pipe_pkg::wb_t      wb,
    input logic               redirect,
    input pipe_pkg::ctrl_t    id_ex_ctrl,
    input logic [`DATA_W-1:0] r0
);

    wb_quiet_in_reset: assert property (@(posedge clk) rst |-> !wb.valid)
        else $error("wb.valid high during reset");

    // taken branch leaves a bubble in ID/EX
    flush_after_redirect: assert property (
        @(posedge clk) disable iff (rst) redirect |=> (id_ex_ctrl == '0))
        else $error("ID/EX control not cleared after redirect");

    r0_stays_zero: assert property (@(posedge clk) r0 == '0)
        else $error("register 0 holds %h", r0);

    no_r0_writeback: assert property (@(posedge clk) wb.valid |-> (wb.rd != '0))
        else $error("write-back targets register 0");

endmodule

bind core_slice core_slice_props u_props (
    .clk(clk), .rst(rst), .wb(wb), .redirect(redirect),
    .id_ex_ctrl(id_ex_q.ctrl), .r0(u_rf.regs[0])
);

/* test/tb_core_slice.sv */
`timescale 1ns/10ps
`include "cpu_settings.svh"

module tb_core_slice;

    localparam int n_rst       = 10;
    localparam int n_alu       = 80;
    localparam int n_haz       = 80;
    localparam int n_br        = 80;
    localparam int n_r0        = 60;
    localparam int cycle_limit = (n_rst + n_alu + n_haz + n_br + n_r0) * 2 + 50;

    typedef struct packed {
        logic [31:0]        due;
        logic [`REG_AW-1:0] rd;
        logic [`DATA_W-1:0] data;
    } exp_wb_t;

    typedef struct packed {
        logic [31:0]        due;
        logic               taken;
        logic [`DATA_W-1:0] target;
    } exp_br_t;

    logic               clk;
    logic               rst;
    logic               instr_valid;
    logic [31:0]        instr;
    logic [`DATA_W-1:0] pc;
    pipe_pkg::wb_t      wb;
    logic               redirect;
    logic [`DATA_W-1:0] redirect_pc;

    logic [31:0]        rng;
    logic [`DATA_W-1:0] model_regs [`NUM_REGS];
    logic [`DATA_W-1:0] pc_next;
    logic               squash;  // next slot dies behind a taken beq
    logic [4:0]         hist0;
    logic [4:0]         hist1;
    int                 cyc;
    int                 checks;
    int                 errors;
    int                 checks0;
    int                 errors0;
    string              test_name;
    exp_wb_t            wb_q [$];
    exp_br_t            br_q [$];

    core_slice UUT (
        .clk(clk), .rst(rst), .instr_valid(instr_valid), .instr(instr), .pc(pc),
        .wb(wb), .redirect(redirect), .redirect_pc(redirect_pc)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc > cycle_limit) begin
            $display("run stopped by timeout after %0d cycles", cyc);
            $display("test failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    // kind 0-5 add sub and or slt sll, 6 addi, 7 addiu, 8 andi, 9 lui, 10 beq
    function automatic logic [31:0] encode(input int kind, input logic [4:0] s,
                                           input logic [4:0] t, input logic [4:0] d,
                                           input logic [15:0] imm);
        isa_pkg::funct_e fn;
        case (kind)
            0:       fn = isa_pkg::fn_add;
            1:       fn = isa_pkg::fn_sub;
            2:       fn = isa_pkg::fn_and;
            3:       fn = isa_pkg::fn_or;
            4:       fn = isa_pkg::fn_slt;
            default: fn = isa_pkg::fn_sll;
        endcase
        case (kind)
            6:       return {isa_pkg::op_addi, s, d, imm};
            7:       return {isa_pkg::op_addiu, s, d, imm};
            8:       return {isa_pkg::op_andi, s, d, imm};
            9:       return {isa_pkg::op_lui, s, d, imm};
            10:      return {isa_pkg::op_beq, s, t, imm};
            default: return {isa_pkg::op_rtype, s, t, d, (kind == 5) ? imm[4:0] : 5'd0, fn};
        endcase
    endfunction

    function automatic logic [31:0] model_result(input int kind, input logic [31:0] x,
                                                 input logic [31:0] y, input logic [15:0] imm);
        case (kind)
            0:       return x + y;
            1:       return x - y;
            2:       return x & y;
            3:       return x | y;
            4:       return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            5:       return y << imm[4:0];
            6, 7:    return x + {{16{imm[15]}}, imm}; // wraps without trap
            8:       return x & {16'h0000, imm};
            default: return {imm, 16'h0000};
        endcase
    endfunction

    task report_mismatch(input string what, input logic [31:0] exp, input logic [31:0] act);
        $display("Fail %s %s: expected %h, actual %h", test_name, what, exp, act);
        errors++;
    endtask

    task report_problem(input string msg);
        $display("Error in %s: %s", test_name, msg);
        errors++;
    endtask

    // one fetch slot run by the model in program order
    task automatic slot(input logic v, input int kind, input logic [4:0] s, input logic [4:0] t,
                        input logic [4:0] d, input logic [15:0] imm);
        logic [31:0] x;
        logic [31:0] y;
        exp_wb_t     ew;
        exp_br_t     eb;
        @(posedge clk);
        instr_valid <= v;
        instr       <= v ? encode(kind, s, t, d, imm) : next_rand();
        pc          <= pc_next;
        x = model_regs[s];
        y = model_regs[t];
        if (squash) begin
            squash = 1'b0;
        end else if (v && kind == 10) begin
            squash    = (x == y);
            eb.due    = cyc + 2; // in EX one cycle after capture
            eb.taken  = squash;
            eb.target = pc_next + 4 + {{14{imm[15]}}, imm, 2'b00};
            br_q.push_back(eb);
        end else if (v && d != 5'd0) begin
            ew.due  = cyc + 3;
            ew.rd   = d;
            ew.data = model_result(kind, x, y, imm);
            model_regs[d] = ew.data;
            wb_q.push_back(ew);
        end
        pc_next = pc_next + 4;
    endtask

    task begin_test(input string name);
        test_name = name;
        checks0   = checks;
        errors0   = errors;
    endtask

    task end_test();
        while (wb_q.size() != 0 || br_q.size() != 0)
            slot(1'b0, 0, 5'd0, 5'd0, 5'd0, 16'h0000);
        $display("%s: %0d checks, %0d errors", test_name, checks - checks0, errors - errors0);
    endtask

    // mode 0 alu, 1 dependent chain, 2 branches, 3 r0 and bubbles
    task automatic random_test(input string name, input int n, input int mode);
        logic [31:0] r;
        logic [31:0] q;
        logic [4:0]  a;
        logic [4:0]  b;
        logic [4:0]  dst;
        logic        v;
        int          kind;
        begin_test(name);
        for (int i = 0; i < n; i++) begin
            r    = next_rand();
            q    = next_rand();
            v    = (mode == 1) || (r[1:0] != 2'd0);
            kind = q[31:16] % 10;
            a    = {2'b00, r[4:2]};
            b    = {2'b00, r[7:5]};
            dst  = {2'b00, r[10:8]};
            case (mode)
                1: begin
                    a   = r[2] ? hist0 : hist1; // distance 1 or 2
                    b   = r[3] ? hist1 : hist0;
                    dst = (r[10:8] == 3'd0) ? 5'd4 : dst;
                end
                2: begin
                    kind = (r[12:11] == 2'd0) ? 10 : kind;
                    b    = r[13] ? a : b; // equal regs force a taken branch
                end
                3: begin
                    a   = r[14] ? 5'd0 : a;
                    b   = r[15] ? 5'd0 : b;
                    dst = r[16] ? 5'd0 : dst;
                end
                default: ;
            endcase
            slot(v, kind, a, b, dst, q[15:0]);
            hist1 = hist0;
            hist0 = dst;
        end
        end_test();
    endtask

    always @(negedge clk) begin
        exp_wb_t ew;
        exp_br_t eb;
        logic    exp_redirect;
        exp_redirect = 1'b0;
        if (br_q.size() != 0 && br_q[0].due == cyc) begin
            eb = br_q.pop_front();
            exp_redirect = eb.taken;
            if (eb.taken) begin
                checks++;
                assert (redirect_pc == eb.target)
                    else report_mismatch("redirect_pc", eb.target, redirect_pc);
            end
        end
        checks++;
        assert (redirect == exp_redirect)
            else report_mismatch("redirect", 32'(exp_redirect), 32'(redirect));
        if (wb_q.size() != 0 && wb_q[0].due == cyc) begin
            ew = wb_q.pop_front();
            checks++;
            assert (wb.valid)
                else report_problem($sformatf("no write-back to r%0d in its cycle", ew.rd));
            assert (wb.rd == ew.rd) else report_mismatch("wb.rd", 32'(ew.rd), 32'(wb.rd));
            assert (wb.data == ew.data) else report_mismatch("wb.data", ew.data, wb.data);
        end else begin
            checks++;
            assert (!wb.valid)
                else report_problem($sformatf("unexpected write-back to r%0d", wb.rd));
        end
    end

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        instr_valid = 1'b1; // live traffic while reset holds
        instr       = encode(6, 5'd0, 5'd0, 5'd1, 16'h0055);
        pc          = '0;
        rng         = 32'd50;
        pc_next     = 32'h0040_0000;
        squash      = 1'b0;
        hist0       = 5'd1;
        hist1       = 5'd2;
        cyc         = 0;
        checks      = 0;
        errors      = 0;
        for (int i = 0; i < `NUM_REGS; i++)
            model_regs[i] = '0;

        begin_test("reset");
        repeat (2) @(posedge clk);
        instr <= encode(10, 5'd0, 5'd0, 5'd0, 16'h0010); // beq on r0 would redirect
        repeat (2) @(posedge clk);
        rst         <= 1'b0;
        instr_valid <= 1'b0;
        repeat (n_rst - 5) slot(1'b0, 0, 5'd0, 5'd0, 5'd0, 16'h0000);
        slot(1'b1, 6, 5'd0, 5'd0, 5'd1, 16'h1234); // first write after reset
        end_test();

        random_test("alu", n_alu, 0);
        random_test("hazard", n_haz, 1);
        random_test("branch", n_br, 2);
        random_test("r0_bubble", n_r0, 3);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+source
source/isa_pkg.sv
source/pipe_pkg.sv
source/decoder.sv
source/reg_file.sv
source/id_ex_reg.sv
source/ex_stage.sv
source/core_slice.sv
test/core_slice_props.sv
test/tb_core_slice.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_core_slice
OBJ_DIR   ?= obj_dir
FILELIST  ?= sim.f
VFLAGS    ?= --binary --assert --timescale 1ns/10ps
PASS_MSG  ?= test passed

SOURCES := $(wildcard source/*.sv source/*.svh test/*.sv)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
